// ==== design/conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// ---------------------------------------------------------------------
// sram format
// ---------------------------------------------------------------------
`define CONV_ADDR_W 12
`define CONV_WORD_W 16
`define CONV_END_MARKER 16'hffff

// pixel and weight bytes, header size field
`define CONV_PIX_W 8
`define CONV_SIZE_W 8

// signed sum of nine products
`define CONV_ACC_W 20

// ---------------------------------------------------------------------
// kernel geometry
// ---------------------------------------------------------------------
`define CONV_KERNEL 3
`define CONV_TAPS 9
// nine weights packed two per word
`define CONV_WEIGHT_WORDS 5

`endif

// ==== design/conv_pkg.sv ====
`include "conv_defs.svh"

package conv_pkg;

  // scalar types
  typedef logic [`CONV_ADDR_W-1:0] sram_addr_t;
  typedef logic [`CONV_SIZE_W-1:0] mat_size_t;
  typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // header view, size in the low byte
  typedef struct packed {
    logic [`CONV_WORD_W-`CONV_SIZE_W-1:0] reserved;
    mat_size_t                            size;
  } header_t;

  // pixel view, low byte comes first in memory
  typedef struct packed {
    pixel_t hi;
    pixel_t lo;
  } pixel_pair_t;

  typedef union packed {
    header_t     hdr;
    pixel_pair_t pix;
  } sram_word_u;

  // control for one tap, travels with the read addresses
  typedef struct packed {
    logic first;
    logic last;
    logic pix_hi;
    logic wgt_hi;
  } tap_ctrl_t;

  typedef struct packed {
    logic valid;
    acc_t sum;
  } conv_result_t;

endpackage

// ==== design/conv_sequencer.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module conv_sequencer
  import conv_pkg::*;
(
  input  logic       clk,
  input  logic       reset_b,
  input  logic       dut_run,
  input  sram_word_u input_word,
  input  logic       matrix_done,
  output logic       header_fetch,
  output logic       start,
  output sram_addr_t header_addr,
  output mat_size_t  size,
  output logic       dut_busy
);

  localparam int AREA_W = 2 * `CONV_SIZE_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR_ADDR,
    ST_HDR_CHECK,
    ST_CONV
  } seq_state_t;

  seq_state_t        state;
  seq_state_t        next_state;
  logic              is_end;
  logic [AREA_W-1:0] area;
  sram_addr_t        matrix_span;

  // ---------------------------------------------------------------------
  // state machine
  // ---------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      state <= ST_IDLE;
    else
      state <= next_state;
  end

  // whole word compared, not just the size byte
  assign is_end = (input_word == `CONV_END_MARKER);

  always_comb
  begin
    next_state = state;
    case (state)
      ST_IDLE:
        if (dut_run)
          next_state = ST_HDR_ADDR;
      ST_HDR_ADDR:
        next_state = ST_HDR_CHECK;
      ST_HDR_CHECK:
        next_state = is_end ? ST_IDLE : ST_CONV;
      ST_CONV:
        if (matrix_done)
          next_state = ST_HDR_ADDR;
      default:
        next_state = ST_IDLE;
    endcase
  end

  assign header_fetch = (state == ST_HDR_ADDR);
  assign start        = (state == ST_HDR_CHECK) && !is_end;

  // ---------------------------------------------------------------------
  // header address and matrix size
  // ---------------------------------------------------------------------
  // header word plus N*N/2 pixel words
  assign area        = AREA_W'(size) * AREA_W'(size);
  assign matrix_span = sram_addr_t'(area >> 1) + sram_addr_t'(1);

  always_ff @(posedge clk)
  begin
    if (!reset_b)
      header_addr <= '0;
    else if (state == ST_IDLE && dut_run)
      header_addr <= '0;
    else if (matrix_done)
      header_addr <= header_addr + matrix_span;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_b)
      size <= '0;
    else if (start)
      size <= input_word.hdr.size;
  end

  // busy from the first header address until the end marker is seen
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      dut_busy <= 1'b0;
    else
      dut_busy <= (next_state != ST_IDLE);
  end

endmodule

// ==== design/window_addr_gen.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module window_addr_gen
  import conv_pkg::*;
(
  input  logic       clk,
  input  logic       reset_b,
  input  logic       header_fetch,
  input  logic       start,
  input  sram_addr_t header_addr,
  input  mat_size_t  size,
  output sram_addr_t input_read_address,
  output sram_addr_t weight_read_address,
  output tap_ctrl_t  tap,
  output logic       matrix_done
);

  localparam int TAP_W     = $clog2(`CONV_TAPS);
  localparam int WGT_IDX_W = $clog2(`CONV_WEIGHT_WORDS);
  localparam logic [1:0] TAP_LAST = 2'(`CONV_KERNEL - 1);

  logic                 active;
  logic [1:0]           tap_row;
  logic [1:0]           tap_col;
  mat_size_t            win_row;
  mat_size_t            win_col;

  logic                 tap_row_end;
  logic                 tap_col_end;
  logic                 win_row_end;
  logic                 win_col_end;
  mat_size_t            win_last;
  mat_size_t            pix_row;
  mat_size_t            pix_col;
  sram_addr_t           pix_index;
  sram_addr_t           pixel_base;
  logic [TAP_W-1:0]     tap_idx;
  logic [WGT_IDX_W-1:0] wgt_word;

  // ---------------------------------------------------------------------
  // window and tap counters
  // ---------------------------------------------------------------------
  assign win_last    = size - mat_size_t'(`CONV_KERNEL);
  assign tap_col_end = (tap_col == TAP_LAST);
  assign tap_row_end = (tap_row == TAP_LAST);
  assign win_col_end = (win_col == win_last);
  assign win_row_end = (win_row == win_last);

  assign matrix_done = active && tap_row_end && tap_col_end && win_row_end && win_col_end;

  always_ff @(posedge clk)
  begin
    if (!reset_b)
      active <= 1'b0;
    else if (start)
      active <= 1'b1;
    else if (matrix_done)
      active <= 1'b0;
  end

  // taps run column first, windows row-major
  always_ff @(posedge clk)
  begin
    if (!reset_b || start)
    begin
      tap_row <= '0;
      tap_col <= '0;
      win_row <= '0;
      win_col <= '0;
    end
    else if (active)
    begin
      if (tap_col_end)
      begin
        tap_col <= '0;
        if (tap_row_end)
        begin
          tap_row <= '0;
          if (win_col_end)
          begin
            win_col <= '0;
            win_row <= win_row_end ? '0 : win_row + mat_size_t'(1);
          end
          else
            win_col <= win_col + mat_size_t'(1);
        end
        else
          tap_row <= tap_row + 2'd1;
      end
      else
        tap_col <= tap_col + 2'd1;
    end
  end

  // ---------------------------------------------------------------------
  // read addresses
  // ---------------------------------------------------------------------
  assign pix_row    = win_row + mat_size_t'(tap_row);
  assign pix_col    = win_col + mat_size_t'(tap_col);
  assign pix_index  = sram_addr_t'(pix_row) * sram_addr_t'(size) + sram_addr_t'(pix_col);
  assign pixel_base = header_addr + sram_addr_t'(1);

  assign input_read_address = header_fetch ? header_addr : pixel_base + (pix_index >> 1);

  // flattened kernel index, two weights per word
  assign tap_idx  = TAP_W'(tap_row) * TAP_W'(`CONV_KERNEL) + TAP_W'(tap_col);
  assign wgt_word = tap_idx[TAP_W-1:1];

  assign weight_read_address = sram_addr_t'(wgt_word);

  // all zero outside a matrix so no strobe leaks out
  always_comb
  begin
    tap.first  = active && (tap_row == 2'd0) && (tap_col == 2'd0);
    tap.last   = active && tap_row_end && tap_col_end;
    tap.pix_hi = active && pix_index[0];
    tap.wgt_hi = active && tap_idx[0];
  end

endmodule

// ==== design/mac_unit.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module mac_unit
  import conv_pkg::*;
(
  input  logic         clk,
  input  logic         reset_b,
  input  tap_ctrl_t    tap,
  input  sram_word_u   input_word,
  input  sram_word_u   weight_word,
  output conv_result_t result
);

  tap_ctrl_t                      tap_q;
  pixel_t                         pix_sel;
  pixel_t                         wgt_sel;
  logic signed [2*`CONV_PIX_W-1:0] product;
  acc_t                           product_ext;
  acc_t                           sum_next;
  acc_t                           acc;
  logic                           result_valid;
  acc_t                           result_sum;

  // ---------------------------------------------------------------------
  // align tap control with the sram data
  // ---------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      tap_q <= '0;
    else
      tap_q <= tap;
  end

  // byte select
  assign pix_sel = tap_q.pix_hi ? input_word.pix.hi : input_word.pix.lo;
  assign wgt_sel = tap_q.wgt_hi ? weight_word.pix.hi : weight_word.pix.lo;

  // ---------------------------------------------------------------------
  // multiply-accumulate
  // ---------------------------------------------------------------------
  assign product     = pix_sel * wgt_sel;
  assign product_ext = acc_t'(product);
  assign sum_next    = tap_q.first ? product_ext : acc + product_ext;

  // runs freely between matrices, the first tap reloads it
  always_ff @(posedge clk)
  begin
    acc <= sum_next;
  end

  // result strobe one cycle after the aligned last tap
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      result_valid <= 1'b0;
    else
      result_valid <= tap_q.last;
  end

  // sum holds until the next strobe
  always_ff @(posedge clk)
  begin
    if (tap_q.last)
      result_sum <= sum_next;
  end

  assign result = '{valid: result_valid, sum: result_sum};

endmodule

// ==== design/conv_engine_top.sv ====
`timescale 1ns/1ns

module conv_engine_top
  import conv_pkg::*;
(
  input  logic         clk,
  input  logic         reset_b,
  input  logic         dut_run,
  output sram_addr_t   input_sram_read_address,
  input  sram_word_u   input_sram_read_data,
  output sram_addr_t   weights_sram_read_address,
  input  sram_word_u   weights_sram_read_data,
  output conv_result_t result,
  output logic         dut_busy
);

  logic       header_fetch;
  logic       start;
  sram_addr_t header_addr;
  mat_size_t  size;
  logic       matrix_done;
  tap_ctrl_t  tap;

  // matrix level control
  conv_sequencer u_sequencer (
    .clk          (clk),
    .reset_b      (reset_b),
    .dut_run      (dut_run),
    .input_word   (input_sram_read_data),
    .matrix_done  (matrix_done),
    .header_fetch (header_fetch),
    .start        (start),
    .header_addr  (header_addr),
    .size         (size),
    .dut_busy     (dut_busy)
  );

  // one tap per cycle, addresses and tap control together
  window_addr_gen u_addr_gen (
    .clk                 (clk),
    .reset_b             (reset_b),
    .header_fetch        (header_fetch),
    .start               (start),
    .header_addr         (header_addr),
    .size                (size),
    .input_read_address  (input_sram_read_address),
    .weight_read_address (weights_sram_read_address),
    .tap                 (tap),
    .matrix_done         (matrix_done)
  );

  mac_unit u_mac (
    .clk         (clk),
    .reset_b     (reset_b),
    .tap         (tap),
    .input_word  (input_sram_read_data),
    .weight_word (weights_sram_read_data),
    .result      (result)
  );

endmodule

// ==== bench/conv_chk.sv ====
`timescale 1ns/1ns

module conv_chk
  import conv_pkg::*;
(
  input logic         clk,
  input logic         reset_b,
  input conv_result_t result,
  input logic         dut_busy,
  input sram_addr_t   input_sram_read_address
);

  logic [3:0] since_strobe;

  // cycles since the last result strobe, saturating
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      since_strobe <= 4'hf;
    else if (result.valid)
      since_strobe <= 4'd0;
    else if (since_strobe != 4'hf)
      since_strobe <= since_strobe + 4'd1;
  end

  a_valid_in_busy: assert property (@(posedge clk) disable iff (!reset_b)
    result.valid |-> dut_busy)
    else $error("result strobe outside a busy run");

  // one window takes nine taps
  a_strobe_spacing: assert property (@(posedge clk) disable iff (!reset_b)
    result.valid |-> (since_strobe >= 4'd8))
    else $error("two result strobes within 8 cycles");

  a_addr_known: assert property (@(posedge clk) disable iff (!reset_b)
    dut_busy |-> !$isunknown(input_sram_read_address))
    else $error("input read address has unknown bits while busy");

endmodule

// ==== bench/conv_tb.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module conv_tb
  import conv_pkg::*;
();

  localparam int MEM_WORDS   = 2 ** `CONV_ADDR_W;
  localparam int RUN_TIMEOUT = 5000;
  localparam integer RANDOM_SEED = 32'h4e98bac1;

  logic         clk;
  logic         reset_b;
  logic         dut_run;
  sram_addr_t   input_addr;
  sram_addr_t   weight_addr;
  sram_word_u   input_data;
  sram_word_u   weight_data;
  conv_result_t result;
  logic         dut_busy;

  logic [`CONV_WORD_W-1:0] input_mem [0:MEM_WORDS-1];
  logic [`CONV_WORD_W-1:0] weight_mem [0:MEM_WORDS-1];
  pixel_t                  wgt [0:`CONV_TAPS-1];
  pixel_t                  img [0:MEM_WORDS-1];
  acc_t                    exp_q [$];
  int                      wr_addr;
  integer                  seed;

  conv_engine_top u_dut (
    .clk                       (clk),
    .reset_b                   (reset_b),
    .dut_run                   (dut_run),
    .input_sram_read_address   (input_addr),
    .input_sram_read_data      (input_data),
    .weights_sram_read_address (weight_addr),
    .weights_sram_read_data    (weight_data),
    .result                    (result),
    .dut_busy                  (dut_busy)
  );

  bind conv_engine_top conv_chk u_chk (
    .clk                     (clk),
    .reset_b                 (reset_b),
    .result                  (result),
    .dut_busy                (dut_busy),
    .input_sram_read_address (input_sram_read_address)
  );

  always #4 clk = ~clk;

  // synchronous srams, data one edge after the address
  always @(posedge clk)
  begin
    input_data  <= input_mem[input_addr];
    weight_data <= weight_mem[weight_addr];
  end

  // ----------------------------------------------------------------------
  // failure reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_sum(input string name, input acc_t expected, input acc_t actual);
    if (actual !== expected)
      abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                          $time, name, expected, actual));
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
                          $time, name, expected, actual));
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected)
      abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                          $time, name, expected, actual));
  endtask

  // ----------------------------------------------------------------------
  // memory layout and reference model
  // ----------------------------------------------------------------------
  // high nibble keeps the fill away from the end marker
  function automatic logic [`CONV_WORD_W-1:0] fill_word(input int a);
    return {4'h3, sram_addr_t'(a)};
  endfunction

  task automatic clear_layout();
    for (int a = 0; a < MEM_WORDS; a++)
    begin
      input_mem[sram_addr_t'(a)]  = fill_word(a);
      weight_mem[sram_addr_t'(a)] = ~fill_word(a);
    end
    wr_addr = 0;
    exp_q.delete();
  endtask

  task automatic load_weights(input bit centre_only);
    pixel_t hi;
    for (int k = 0; k < `CONV_TAPS; k++)
    begin
      if (centre_only)
        wgt[4'(k)] = (k == 4) ? 8'sd1 : 8'sd0;
      else
        wgt[4'(k)] = pixel_t'($random(seed));
    end
    // extremes of the signed range
    if (!centre_only)
    begin
      wgt[0] = -8'sd128;
      wgt[8] = 8'sd127;
    end
    for (int w = 0; w < `CONV_WEIGHT_WORDS; w++)
    begin
      hi = (2 * w + 1 < `CONV_TAPS) ? wgt[4'(2 * w + 1)] : 8'sd0;
      weight_mem[sram_addr_t'(w)] = {hi, wgt[4'(2 * w)]};
    end
  endtask

  // header, packed pixels, and the expected sums in window order
  task automatic add_matrix(input int n, input bit random_pixels);
    int sum;
    input_mem[sram_addr_t'(wr_addr)] = {8'h00, mat_size_t'(n)};
    for (int k = 0; k < n * n; k++)
      img[sram_addr_t'(k)] = random_pixels ? pixel_t'($random(seed)) : pixel_t'(k + 1);
    if (random_pixels)
    begin
      img[0] = -8'sd128;
      img[sram_addr_t'(n * n - 1)] = 8'sd127;
    end
    for (int k = 0; k < n * n / 2; k++)
      input_mem[sram_addr_t'(wr_addr + 1 + k)] =
        {img[sram_addr_t'(2 * k + 1)], img[sram_addr_t'(2 * k)]};
    for (int r = 0; r <= n - `CONV_KERNEL; r++)
    begin
      for (int c = 0; c <= n - `CONV_KERNEL; c++)
      begin
        sum = 0;
        for (int i = 0; i < `CONV_KERNEL; i++)
          for (int j = 0; j < `CONV_KERNEL; j++)
            sum += int'(img[sram_addr_t'((r + i) * n + c + j)]) *
                   int'(wgt[4'(i * `CONV_KERNEL + j)]);
        exp_q.push_back(acc_t'(sum));
      end
    end
    wr_addr += 1 + n * n / 2;
  endtask

  task automatic add_end();
    input_mem[sram_addr_t'(wr_addr)] = `CONV_END_MARKER;
  endtask

  // ----------------------------------------------------------------------
  // one run, every strobe checked in order
  // ----------------------------------------------------------------------
  task automatic run_engine();
    acc_t run_q [$];
    int   n_exp;
    int   got;
    int   cycles;
    run_q = exp_q;
    n_exp = run_q.size();
    got = 0;
    cycles = 0;
    @(negedge clk);
    dut_run = 1'b1;
    @(negedge clk);
    dut_run = 1'b0;
    check_bit("dut_busy", 1'b1, dut_busy);
    while (dut_busy)
    begin
      if (result.valid)
      begin
        if (run_q.size() == 0)
          abort_run("result strobe seen after all expected sums were taken");
        check_sum($sformatf("result.sum[%0d]", got), run_q.pop_front(), result.sum);
        got++;
      end
      cycles++;
      if (cycles > RUN_TIMEOUT)
        abort_run("timed out waiting for dut_busy to fall at the end of a run");
      @(negedge clk);
    end
    // nothing may trail the end of the run
    for (int k = 0; k < 4; k++)
    begin
      check_bit("result.valid", 1'b0, result.valid);
      @(negedge clk);
    end
    check_count("result count", n_exp, got);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic idle_after_reset();
    for (int k = 0; k < 20; k++)
    begin
      check_bit("dut_busy", 1'b0, dut_busy);
      check_bit("result.valid", 1'b0, result.valid);
      @(negedge clk);
    end
  endtask

  task automatic centre_kernel_4x4();
    clear_layout();
    load_weights(1'b1);
    add_matrix(4, 1'b0);
    add_end();
    run_engine();
  endtask

  task automatic build_random_8x8();
    seed = RANDOM_SEED;
    clear_layout();
    load_weights(1'b0);
    add_matrix(8, 1'b1);
    add_end();
  endtask

  task automatic random_8x8_matrix();
    build_random_8x8();
    run_engine();
  endtask

  task automatic two_matrices_back_to_back();
    clear_layout();
    load_weights(1'b0);
    add_matrix(6, 1'b1);
    add_matrix(4, 1'b1);
    add_end();
    run_engine();
  endtask

  task automatic end_marker_first();
    clear_layout();
    add_end();
    run_engine();
  endtask

  // second run reads the same layout from address 0 again
  task automatic rerun_from_zero();
    build_random_8x8();
    run_engine();
    run_engine();
  endtask

  initial
  begin
    clk = 1'b0;
    reset_b = 1'b0;
    dut_run = 1'b0;
    seed = RANDOM_SEED;
    clear_layout();
    repeat (16) @(negedge clk);
    reset_b = 1'b1;
    idle_after_reset();
    centre_kernel_4x4();
    random_8x8_matrix();
    two_matrices_back_to_back();
    end_marker_first();
    rerun_from_zero();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/conv_pkg.sv
design/conv_sequencer.sv
design/window_addr_gen.sv
design/mac_unit.sv
design/conv_engine_top.sv
bench/conv_chk.sv
bench/conv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= conv_tb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# a $fatal or a failed assertion gives a nonzero exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
